/* Makefile */
TOP = psram_ctrl_tb
SRCS = common/psram_pkg.sv rtl/psram_fifo.sv rtl/psram_io.sv \
	sequencer/psram_sequencer.sv rtl/psram_ctrl_top.sv \
	tb/psram_model.sv tb/psram_ctrl_tb.sv

obj_dir/V$(TOP): psram_ctrl.f $(SRCS)
	verilator --binary --timing --assert --top-module $(TOP) -f psram_ctrl.f -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* common/psram_pkg.sv */
/* Widths, opcodes, burst lengths and bundle types shared by the PSRAM controller.
   Each RTL module pulls these in with a wildcard import. */
`default_nettype none

package psram_pkg;

	////////////////////////////////////////
	// Widths and burst lengths
	////////////////////////////////////////
	localparam int ADDR_W = 25;	// Word address
	localparam int WORD_W = 16;
	localparam int ID_W = 32;

	localparam int RD_BURST = 4;	// Words per read burst
	localparam int WR_BURST = 8;	// Words per write burst
	localparam int ID_WORDS = 2;

	////////////////////////////////////////
	// Device opcodes, sent twice per command word
	////////////////////////////////////////
	localparam logic [7:0] OP_RESET_EN = 8'h66;
	localparam logic [7:0] OP_RESET = 8'h99;
	localparam logic [7:0] OP_READ_ID = 8'h9F;
	localparam logic [7:0] OP_WRITE_EN = 8'h06;
	localparam logic [7:0] OP_WRITE_REG = 8'h71;
	localparam logic [7:0] OP_READ = 8'hEE;
	localparam logic [7:0] OP_WRITE = 8'hDE;

	// CR0 setting for latency 3
	localparam logic [WORD_W-1:0] CR0_VALUE = 16'h4FEF;

	// One bus cycle worth of pad values
	typedef struct packed {
		logic cs;
		logic clk_en;	// Serial clock runs this cycle
		logic oe;
		logic [WORD_W-1:0] data;
	} psram_pads_t;

	// Queued request
	typedef struct packed {
		logic write;
		logic [ADDR_W-1:0] addr;
	} psram_cmd_t;

endpackage

`default_nettype wire

/* psram_ctrl.f */
common/psram_pkg.sv
rtl/psram_fifo.sv
rtl/psram_io.sv
sequencer/psram_sequencer.sv
rtl/psram_ctrl_top.sv
tb/psram_model.sv
tb/psram_ctrl_tb.sv

/* rtl/psram_ctrl_top.sv */
/* Top level of the PSRAM controller. Queues AXI-like read and write requests
   and hands them to the frame sequencer, which drives the device pads. */
`timescale 1ns/1ns
`default_nettype none

module psram_ctrl_top import psram_pkg::*; #(
	parameter int STARTUP_CYCLES = 7200,
	parameter int RESET_WAIT_CYCLES = 20,
	parameter int ID_LATENCY = 14,
	parameter int MEM_LATENCY = 6,
	parameter int WDATA_DEPTH = 16
) (
	input wire logic clk,
	input wire logic reset,

	// Request side
	input wire logic arvalid,
	input wire logic [ADDR_W-1:0] araddr,
	output logic arready,
	input wire logic awvalid,
	input wire logic [ADDR_W-1:0] awaddr,
	output logic awready,
	input wire logic wvalid,
	input wire logic [WORD_W-1:0] wdata,
	output logic wready,
	output logic bvalid,
	output logic rvalid,
	output logic [WORD_W-1:0] rdata,

	// Status
	output logic psram_ready,
	output logic [ID_W-1:0] dev_id,

	// Device pads
	output logic spi_cs,
	output logic spi_clk_en,
	output logic spi_data_oe,
	output logic [WORD_W-1:0] spi_data_out,
	input wire logic [WORD_W-1:0] spi_data_in,
	input wire logic spi_rwds_in
);
	localparam int WC_W = $clog2(WDATA_DEPTH + 1);

	psram_cmd_t cmd_in;
	psram_cmd_t cmd_head;
	psram_pads_t pads;
	logic ar_take, cmd_push, cmd_pop, cmd_full, cmd_empty;
	logic [WORD_W-1:0] wdata_head;
	logic [WC_W-1:0] wdata_count;
	logic wdata_full, wdata_pop;
	logic init_done;
	logic [WORD_W-1:0] rd_word;
	logic rd_strobe;

	////////////////////////////////////////
	// Request acceptance
	////////////////////////////////////////
	assign arready = init_done && !cmd_full;
	assign awready = init_done && !cmd_full && !arvalid;	// Read wins a tie
	assign wready = init_done && !wdata_full;
	assign psram_ready = init_done;

	assign ar_take = arvalid && arready;
	assign cmd_push = ar_take || (awvalid && awready);
	assign cmd_in.write = !ar_take;
	assign cmd_in.addr = ar_take ? araddr : awaddr;

	psram_fifo #(.T(psram_cmd_t), .DEPTH(2)) cmd_fifo (
		.clk(clk), .reset(reset),
		.push(cmd_push), .push_data(cmd_in), .full(cmd_full),
		.pop(cmd_pop), .pop_data(cmd_head), .empty(cmd_empty), .count()
	);

	psram_fifo #(.T(logic [WORD_W-1:0]), .DEPTH(WDATA_DEPTH)) wdata_fifo (
		.clk(clk), .reset(reset),
		.push(wvalid && wready), .push_data(wdata), .full(wdata_full),
		.pop(wdata_pop), .pop_data(wdata_head), .empty(), .count(wdata_count)
	);

	psram_sequencer #(
		.STARTUP_CYCLES(STARTUP_CYCLES), .RESET_WAIT_CYCLES(RESET_WAIT_CYCLES),
		.ID_LATENCY(ID_LATENCY), .MEM_LATENCY(MEM_LATENCY), .WDATA_DEPTH(WDATA_DEPTH)
	) psram_sequencer_inst (
		.clk(clk), .reset(reset), .init_done(init_done),
		.cmd(cmd_head), .cmd_empty(cmd_empty), .cmd_pop(cmd_pop),
		.wdata(wdata_head), .wdata_count(wdata_count), .wdata_pop(wdata_pop),
		.pads(pads), .rd_word(rd_word), .rd_strobe(rd_strobe),
		.rvalid(rvalid), .rdata(rdata), .bvalid(bvalid), .dev_id(dev_id)
	);

	psram_io psram_io_inst (
		.clk(clk), .reset(reset), .pads_in(pads),
		.spi_cs(spi_cs), .spi_clk_en(spi_clk_en), .spi_data_oe(spi_data_oe),
		.spi_data_out(spi_data_out), .spi_data_in(spi_data_in), .spi_rwds_in(spi_rwds_in),
		.rd_word(rd_word), .rd_strobe(rd_strobe)
	);

endmodule

`default_nettype wire

/* rtl/psram_fifo.sv */
/* Small synchronous FIFO with show-ahead output, payload set by a type parameter.
   Serves both the request queue and the write data queue. */
`timescale 1ns/1ns
`default_nettype none

module psram_fifo #(
	parameter type T = logic,
	parameter int DEPTH = 2
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic push,
	input wire T push_data,
	output logic full,
	input wire logic pop,
	output T pop_data,
	output logic empty,
	output logic [$clog2(DEPTH+1)-1:0] count
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	T mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;

	// Wraps at DEPTH, which need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full = (count == CNT_W'(DEPTH));
	assign empty = (count == '0);
	assign pop_data = mem[rd_ptr];	// Head is visible before the pop

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (reset) !(push && full));
	a_no_underflow: assert property (@(posedge clk) disable iff (reset) !(pop && empty));

endmodule

`default_nettype wire

/* rtl/psram_io.sv */
/* Pad stage of the PSRAM controller. Registers the bus word onto the pads and
   captures strobed read words coming back from the device. */
`timescale 1ns/1ns
`default_nettype none

module psram_io import psram_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire psram_pads_t pads_in,

	// Device pads
	output logic spi_cs,
	output logic spi_clk_en,
	output logic spi_data_oe,
	output logic [WORD_W-1:0] spi_data_out,
	input wire logic [WORD_W-1:0] spi_data_in,
	input wire logic spi_rwds_in,	// Marks a valid read word

	// Back to the sequencer
	output logic [WORD_W-1:0] rd_word,
	output logic rd_strobe
);

	////////////////////////////////////////
	// Outgoing pads, one cycle behind the sequencer
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			spi_cs <= 1'b0;
			spi_clk_en <= 1'b0;
			spi_data_oe <= 1'b0;
		end else begin
			spi_cs <= pads_in.cs;
			spi_clk_en <= pads_in.clk_en;
			spi_data_oe <= pads_in.oe;
		end
	end

	always_ff @(posedge clk) begin
		spi_data_out <= pads_in.data;
	end

	////////////////////////////////////////
	// Incoming read words
	////////////////////////////////////////

	// Only words inside a frame count
	always_ff @(posedge clk) begin
		if (reset)
			rd_strobe <= 1'b0;
		else
			rd_strobe <= spi_rwds_in && spi_cs;
	end

	// Last captured word is held between strobes
	always_ff @(posedge clk) begin
		if (spi_rwds_in && spi_cs)
			rd_word <= spi_data_in;
	end

endmodule

`default_nettype wire

/* sequencer/psram_sequencer.sv */
/* Frame sequencer of the PSRAM controller. Runs startup and device init, then
   dispatches queued read and write bursts, one bus word per clock. */
`timescale 1ns/1ns
`default_nettype none

module psram_sequencer import psram_pkg::*; #(
	parameter int STARTUP_CYCLES = 7200,
	parameter int RESET_WAIT_CYCLES = 20,
	parameter int ID_LATENCY = 14,
	parameter int MEM_LATENCY = 6,
	parameter int WDATA_DEPTH = 16
) (
	input wire logic clk,
	input wire logic reset,
	output logic init_done,

	input wire psram_cmd_t cmd,
	input wire logic cmd_empty,
	output logic cmd_pop,
	input wire logic [WORD_W-1:0] wdata,
	input wire logic [$clog2(WDATA_DEPTH+1)-1:0] wdata_count,
	output logic wdata_pop,

	output psram_pads_t pads,
	input wire logic [WORD_W-1:0] rd_word,
	input wire logic rd_strobe,

	output logic rvalid,
	output logic [WORD_W-1:0] rdata,
	output logic bvalid,
	output logic [ID_W-1:0] dev_id
);
	localparam int WC_W = $clog2(WDATA_DEPTH + 1);
	localparam int SU_W = $clog2(STARTUP_CYCLES + 1);
	localparam int RC_W = $clog2(RD_BURST + 1);
	localparam int MAX_LAT = (ID_LATENCY > MEM_LATENCY) ? ID_LATENCY : MEM_LATENCY;
	localparam int MAX_LEN = (RESET_WAIT_CYCLES > WR_BURST) ? RESET_WAIT_CYCLES : WR_BURST;
	localparam int CNT_W = $clog2(((MAX_LAT > MAX_LEN) ? MAX_LAT : MAX_LEN) + 1);

	typedef enum logic [2:0] {
		S_STARTUP,
		S_CMD,
		S_ADDR_HI,
		S_ADDR_LO,
		S_LATENCY,
		S_DATA,
		S_GAP,	// cs low between init frames
		S_IDLE	// Ready, also the gap after a memory burst
	} step_t;

	typedef enum logic [2:0] {
		F_RESET_EN,
		F_RESET,
		F_READ_ID,
		F_WRITE_EN,
		F_WRITE_REG,
		F_MEM_READ,
		F_MEM_WRITE
	} frame_t;

	step_t step;
	frame_t frame;
	logic [SU_W-1:0] startup_cnt;
	logic [CNT_W-1:0] step_cnt;	// Cycles left in latency, data or gap
	logic [RC_W-1:0] rd_cnt;
	logic [RC_W-1:0] rd_need;
	logic [ADDR_W-1:0] mem_addr;
	logic [2*WORD_W-1:0] addr_ext;
	logic is_read, is_mem, has_addr;
	logic rd_take, rd_done, wr_last, wr_last_q, frame_end;

	function automatic logic [7:0] frame_opcode(input frame_t f);
		case (f)
			F_RESET_EN: return OP_RESET_EN;
			F_RESET: return OP_RESET;
			F_READ_ID: return OP_READ_ID;
			F_WRITE_EN: return OP_WRITE_EN;
			F_WRITE_REG: return OP_WRITE_REG;
			F_MEM_READ: return OP_READ;
			default: return OP_WRITE;
		endcase
	endfunction

	assign is_read = (frame == F_READ_ID) || (frame == F_MEM_READ);
	assign is_mem = (frame == F_MEM_READ) || (frame == F_MEM_WRITE);
	assign has_addr = is_read || (frame == F_WRITE_REG) || (frame == F_MEM_WRITE);
	assign rd_need = (frame == F_READ_ID) ? RC_W'(ID_WORDS) : RC_W'(RD_BURST);
	assign rd_take = rd_strobe && is_read && (step == S_LATENCY || step == S_DATA);
	assign rd_done = (rd_cnt + RC_W'(rd_take)) == rd_need;	// Includes this cycle's word
	assign wr_last = (step == S_DATA) && (frame == F_MEM_WRITE) && (step_cnt == '0);
	assign frame_end = (frame == F_WRITE_REG) || wr_last || (is_read && rd_done);
	assign addr_ext = is_mem ? {{(2*WORD_W-ADDR_W){1'b0}}, mem_addr} : '0;

	// Write burst waits until all its words are queued
	assign cmd_pop = (step == S_IDLE) && !cmd_empty &&
		(!cmd.write || wdata_count >= WC_W'(WR_BURST));
	assign wdata_pop = (step == S_DATA) && (frame == F_MEM_WRITE);

	////////////////////////////////////////
	// Bus word of the current cycle
	////////////////////////////////////////
	always_comb begin
		pads = '0;
		case (step)
			S_CMD: pads.data = {frame_opcode(frame), frame_opcode(frame)};
			S_ADDR_HI: pads.data = addr_ext[2*WORD_W-1:WORD_W];
			S_ADDR_LO: pads.data = addr_ext[WORD_W-1:0];
			S_DATA: pads.data = (frame == F_MEM_WRITE) ? wdata : CR0_VALUE;
			default: ;
		endcase
		pads.cs = step inside {S_CMD, S_ADDR_HI, S_ADDR_LO, S_LATENCY, S_DATA};
		pads.clk_en = pads.cs;
		pads.oe = (step inside {S_CMD, S_ADDR_HI, S_ADDR_LO}) || (step == S_DATA && !is_read);
	end

	////////////////////////////////////////
	// Phase walk
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			step <= S_STARTUP;
			frame <= F_RESET_EN;
			startup_cnt <= SU_W'(STARTUP_CYCLES);
			step_cnt <= '0;
			rd_cnt <= '0;
			init_done <= 1'b0;
		end else begin
			if (rd_take)
				rd_cnt <= rd_cnt + 1'b1;
			case (step)
				S_STARTUP: begin
					if (startup_cnt == '0)
						step <= S_CMD;
					else
						startup_cnt <= startup_cnt - 1'b1;
				end
				S_CMD: begin
					rd_cnt <= '0;
					if (has_addr) begin
						step <= S_ADDR_HI;
					end else begin
						step <= S_GAP;	// Reset holds cs low for the device wait
						step_cnt <= (frame == F_RESET) ? CNT_W'(RESET_WAIT_CYCLES - 1) : '0;
					end
				end
				S_ADDR_HI: step <= S_ADDR_LO;
				S_ADDR_LO: begin
					if (frame == F_WRITE_REG) begin
						step <= S_DATA;
					end else begin
						step <= S_LATENCY;
						step_cnt <= (frame == F_READ_ID) ? CNT_W'(ID_LATENCY - 1) :
							CNT_W'(MEM_LATENCY - 1);
					end
				end
				S_LATENCY: begin
					if (step_cnt == '0) begin
						step <= S_DATA;
						step_cnt <= CNT_W'(WR_BURST - 1);
					end else begin
						step_cnt <= step_cnt - 1'b1;
					end
				end
				S_DATA: begin
					step_cnt <= step_cnt - 1'b1;
					if (frame_end) begin
						step <= is_mem ? S_IDLE : S_GAP;
						step_cnt <= '0;
					end
				end
				S_GAP: begin
					if (step_cnt != '0) begin
						step_cnt <= step_cnt - 1'b1;
					end else begin
						step <= S_CMD;
						case (frame)
							F_RESET_EN: frame <= F_RESET;
							F_RESET: frame <= F_READ_ID;
							F_READ_ID: frame <= F_WRITE_EN;
							F_WRITE_EN: frame <= F_WRITE_REG;
							default: begin	// CR0 written, init complete
								step <= S_IDLE;
								init_done <= 1'b1;
							end
						endcase
					end
				end
				default: begin	// S_IDLE
					if (cmd_pop) begin
						step <= S_CMD;
						frame <= cmd.write ? F_MEM_WRITE : F_MEM_READ;
					end
				end
			endcase
		end
	end

	// Status and response pulses
	always_ff @(posedge clk) begin
		if (reset) begin
			rvalid <= 1'b0;
			wr_last_q <= 1'b0;
			bvalid <= 1'b0;
			dev_id <= '0;
		end else begin
			rvalid <= rd_take && (frame == F_MEM_READ);
			wr_last_q <= wr_last;	// Last beat is on the pads now
			bvalid <= wr_last_q;
			if (rd_take && frame == F_READ_ID)
				dev_id <= {dev_id[ID_W-WORD_W-1:0], rd_word};	// First word ends up high
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_pop)
			mem_addr <= cmd.addr;
		if (rd_take)
			rdata <= rd_word;
	end

	a_oe_under_cs: assert property (@(posedge clk) disable iff (reset) pads.oe |-> pads.cs);

	// Queue depth seen at the command cycle, one cycle after dispatch
	a_wr_burst_queued: assert property (@(posedge clk) disable iff (reset)
		(step == S_CMD && frame == F_MEM_WRITE) |-> wdata_count >= WC_W'(WR_BURST));

endmodule

`default_nettype wire

/* tb/psram_ctrl_tb.sv */
/* Testbench for the PSRAM controller. Runs init against the device model, then
   random read and write bursts checked against a shadow memory. */
`timescale 1ns/1ns
`default_nettype none

module psram_ctrl_tb import psram_pkg::*; ();
	localparam int ID_LAT = 14;
	localparam int MEM_LAT = 6;
	localparam int N_REQ = 200;
	localparam int TIMEOUT_CYCLES = 20000;	// 200 bursts of under 30 cycles plus init, with margin

	logic clk = 1'b0;
	logic reset;
	logic arvalid, awvalid, wvalid;
	logic [ADDR_W-1:0] araddr, awaddr;
	logic [WORD_W-1:0] wdata;
	logic arready, awready, wready, bvalid, rvalid, psram_ready;
	logic [WORD_W-1:0] rdata;
	logic [ID_W-1:0] dev_id;
	logic spi_cs, spi_clk_en, spi_data_oe, spi_rwds_in;
	logic [WORD_W-1:0] spi_data_out, spi_data_in;

	logic [WORD_W-1:0] shadow [128];
	logic [WORD_W-1:0] exp_rd [$];	// Expected rdata words in order
	logic [WORD_W-1:0] beats [$];	// Write beats still to send
	logic [ADDR_W-1:0] wr_addr_q [$];
	logic [WORD_W-1:0] wr_data_q [$];
	int issued = 0;
	int cycles = 0;
	bit ready_seen = 1'b0;

	psram_ctrl_top #(.STARTUP_CYCLES(50), .ID_LATENCY(ID_LAT), .MEM_LATENCY(MEM_LAT))
	psram_ctrl_inst (
		.clk(clk), .reset(reset),
		.arvalid(arvalid), .araddr(araddr), .arready(arready),
		.awvalid(awvalid), .awaddr(awaddr), .awready(awready),
		.wvalid(wvalid), .wdata(wdata), .wready(wready),
		.bvalid(bvalid), .rvalid(rvalid), .rdata(rdata),
		.psram_ready(psram_ready), .dev_id(dev_id),
		.spi_cs(spi_cs), .spi_clk_en(spi_clk_en), .spi_data_oe(spi_data_oe),
		.spi_data_out(spi_data_out), .spi_data_in(spi_data_in), .spi_rwds_in(spi_rwds_in)
	);

	psram_model #(.ID_LATENCY(ID_LAT), .MEM_LATENCY(MEM_LAT)) psram_model_inst (
		.clk(clk), .reset(reset), .cs(spi_cs), .clk_en(spi_clk_en), .oe(spi_data_oe),
		.din(spi_data_out), .dout(spi_data_in), .rwds(spi_rwds_in)
	);

	always #10 clk = ~clk;

	function automatic logic [6:0] mem_slot(input logic [ADDR_W-1:0] base, input int off);
		return 7'(int'(base) + off);
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("Error: %s got 0x%h expected 0x%h", name, got, exp);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	task automatic stop_with(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1);
	endtask

	initial begin
		void'($urandom(60384));
		for (int i = 0; i < 128; i++) begin
			shadow[i] = 16'(i * 40503) ^ 16'(i << 9) ^ 16'h5A5A;
			psram_model_inst.mem[i] = shadow[i];
		end
		reset = 1'b1;
		arvalid = 1'b0;
		awvalid = 1'b0;
		wvalid = 1'b0;
		araddr = '0;
		awaddr = '0;
		wdata = '0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles", cycles);
			$display("Something failed");
			$fatal(1);
		end
	end

	////////////////////////////////////////
	// Request and write beat driver
	////////////////////////////////////////
	always @(posedge clk) begin
		bit ar_on;
		bit aw_on;
		int r;
		logic [WORD_W-1:0] w;
		if (!reset && psram_ready) begin
			if (arvalid && awvalid)
				compare_value("awready", 32'(awready), 32'h0);	// Read must win
			ar_on = arvalid && !arready;
			aw_on = awvalid && !awready;
			if (arvalid && arready)
				for (int i = 0; i < RD_BURST; i++)
					exp_rd.push_back(shadow[mem_slot(araddr, i)]);
			if (wvalid && wready)
				void'(beats.pop_front());
			if (awvalid && awready) begin
				wr_addr_q.push_back(awaddr);
				for (int i = 0; i < WR_BURST; i++) begin
					w = 16'($urandom);
					shadow[mem_slot(awaddr, i)] = w;
					beats.push_back(w);
					wr_data_q.push_back(w);
				end
			end
			if (!ar_on && !aw_on && issued < N_REQ) begin
				r = int'($urandom % 4);
				ar_on = (r == 0 && issued <= N_REQ - 2) || r == 1;
				aw_on = (r == 0 && issued <= N_REQ - 2) || r >= 2;
				issued <= issued + int'(ar_on) + int'(aw_on);
				araddr <= ADDR_W'($urandom % 64);	// Small window, reads hit writes
				awaddr <= ADDR_W'($urandom % 64);
			end
			arvalid <= ar_on;
			awvalid <= aw_on;
			wvalid <= (beats.size() > 0);
			if (beats.size() > 0)
				wdata <= beats[0];
		end
	end

	////////////////////////////////////////
	// Response checks and end of run
	////////////////////////////////////////
	always @(posedge clk) begin
		logic [ADDR_W-1:0] a;
		if (!reset) begin
			if (!ready_seen) begin
				if (psram_ready) begin
					ready_seen = 1'b1;
					compare_value("dev_id", dev_id, 32'h0E960001);
					compare_value("init frame count", 32'(psram_model_inst.op_count), 32'd5);
					compare_value("op 0", 32'(psram_model_inst.op_log[0]), 32'h6666);
					compare_value("op 1", 32'(psram_model_inst.op_log[1]), 32'h9999);
					compare_value("op 2", 32'(psram_model_inst.op_log[2]), 32'h9F9F);
					compare_value("op 3", 32'(psram_model_inst.op_log[3]), 32'h0606);
					compare_value("op 4", 32'(psram_model_inst.op_log[4]), 32'h7171);
					compare_value("cr0", 32'(psram_model_inst.cr0_seen), 32'(CR0_VALUE));
				end else begin
					compare_value("arready", 32'(arready), 32'h0);
					compare_value("awready", 32'(awready), 32'h0);
					compare_value("wready", 32'(wready), 32'h0);
					compare_value("bvalid", 32'(bvalid), 32'h0);
				end
			end else begin
				compare_value("psram_ready", 32'(psram_ready), 32'h1);
			end

			if (rvalid) begin
				if (exp_rd.size() == 0)
					stop_with("Read word returned with no read pending");
				compare_value("rdata", 32'(rdata), 32'(exp_rd.pop_front()));
			end
			if (bvalid) begin
				if (wr_addr_q.size() == 0)
					stop_with("Write response with no write pending");
				a = wr_addr_q.pop_front();
				for (int i = 0; i < WR_BURST; i++)
					compare_value("model mem", 32'(psram_model_inst.mem[mem_slot(a, i)]),
						32'(wr_data_q.pop_front()));
			end

			if (ready_seen && issued == N_REQ && !arvalid && !awvalid && beats.size() == 0 &&
					exp_rd.size() == 0 && wr_addr_q.size() == 0) begin
				$display("Everything OK");
				$finish;
			end
		end
	end

endmodule

`default_nettype wire

/* tb/psram_model.sv */
/* Behavioral PSRAM device for the testbench. Decodes frames seen on the pads,
   answers ID and memory reads, and stores memory writes. */
`timescale 1ns/1ns
`default_nettype none

module psram_model import psram_pkg::*; #(
	parameter int ID_LATENCY = 14,
	parameter int MEM_LATENCY = 6
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic cs,
	input wire logic clk_en,
	input wire logic oe,
	input wire logic [WORD_W-1:0] din,
	output logic [WORD_W-1:0] dout,
	output logic rwds
);
	logic [WORD_W-1:0] mem [128];	// Small window, filled by the testbench
	logic [WORD_W-1:0] op_log [8];	// Command words of the first frames
	logic [3:0] op_count;
	logic [WORD_W-1:0] cr0_seen;
	logic [7:0] op;
	logic [31:0] addr;
	int idx;	// Cycle number inside the frame

	function automatic logic [6:0] slot(input logic [31:0] base, input int off);
		return 7'(int'(base) + off);
	endfunction

	initial begin
		rwds = 1'b0;
		dout = '0;
	end

	always @(posedge clk) begin
		int nxt;
		if (reset) begin
			idx = 0;
			op_count = '0;
			rwds <= 1'b0;
		end else if (!cs) begin
			idx = 0;
			rwds <= 1'b0;
		end else if (clk_en) begin	// Device only steps on serial clock cycles
			case (idx)
				0: begin
					op = din[7:0];
					if (op_count < 4'd8) begin
						op_log[op_count[2:0]] = din;
						op_count = op_count + 4'd1;
					end
				end
				1: addr[31:16] = din;
				2: addr[15:0] = din;
				default: begin
					if (op == OP_WRITE_REG && idx == 3)
						cr0_seen = din;
					if (op == OP_WRITE && oe && idx >= 3 + MEM_LATENCY)
						mem[slot(addr, idx - 3 - MEM_LATENCY)] <= din;
				end
			endcase

			// Answer words go out on the cycle after this edge
			nxt = idx + 1;
			rwds <= 1'b0;
			if (op == OP_READ_ID && nxt >= 3 + ID_LATENCY && nxt < 3 + ID_LATENCY + ID_WORDS) begin
				rwds <= 1'b1;
				dout <= (nxt == 3 + ID_LATENCY) ? 16'h0E96 : 16'h0001;	// High word first
			end
			if (op == OP_READ && nxt >= 3 + MEM_LATENCY && nxt < 3 + MEM_LATENCY + RD_BURST) begin
				rwds <= 1'b1;
				dout <= mem[slot(addr, nxt - 3 - MEM_LATENCY)];
			end
			idx = nxt;
		end
	end

endmodule

`default_nettype wire
